/* imu_i2c_top.f */
+incdir+common
common/imu_i2c_pkg.sv
i2c_link/i2c_bit_timer.sv
i2c_link/i2c_byte_engine.sv
hw/imu_sequencer.sv
hw/imu_i2c_top.sv
sim/imu_sensor_model.sv
sim/tb_imu_i2c_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_imu_i2c_top
FILELIST  := imu_i2c_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir $(OBJ_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_imu_i2c_top.sv */
// IMU I2C master testbench
`include "imu_i2c_defs.svh"

module tb_imu_i2c_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;
	localparam int DONE_LIMIT = 10000; // a burst takes about 2600 cycles
	localparam int BASE = int'(`IMU_I2C_REG_BURST_BASE);

	typedef enum logic [2:0] {
		PH_RESET,
		PH_IDLE,
		PH_WRITE,
		PH_READ,
		PH_BURST,
		PH_NACK,
		PH_END
	} phase_t;

	logic clk;
	logic rst_n;
	imu_i2c_pkg::cpu_req_t req;
	logic drdy;
	logic nack_addr;
	logic load_en;
	logic [5:0] load_addr;
	logic [7:0] load_data;
	logic dut_scl_low;
	logic dut_sda_low;
	logic model_sda_low;
	logic scl;
	logic sda;
	imu_i2c_pkg::imu_sample_t sample;
	logic [7:0] rd_byte;
	imu_i2c_pkg::imu_status_t status;
	phase_t phase;
	logic [5:0] cpu_ptr;
	logic [7:0] cpu_data;
	logic [5:0] nack_ptr;
	logic [7:0] kept_reg;

	assign scl = !dut_scl_low;
	assign sda = !(dut_sda_low || model_sda_low); // wired and

	always #HALF_PERIOD clk = !clk;

	imu_i2c_top u_imu_i2c_top (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_req     (req),
		.i_drdy    (drdy),
		.i_sda     (sda),
		.o_scl_low (dut_scl_low),
		.o_sda_low (dut_sda_low),
		.o_sample  (sample),
		.o_rd_byte (rd_byte),
		.o_status  (status)
	);

	imu_sensor_model u_sensor (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_scl       (scl),
		.i_sda       (sda),
		.i_nack_addr (nack_addr),
		.i_load_en   (load_en),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.o_sda_low   (model_sda_low)
	);

	task automatic check_failed(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench check failed");
	endtask

	task automatic timed_out(input string what);
		$display("The DUT gave no done within %0d cycles during the %s", DONE_LIMIT, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench timeout");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_cpu_req(input imu_i2c_pkg::cpu_mode_t mode, input logic [5:0] ptr,
			input logic [7:0] data);
		next_cycle();
		req.start = 1'b1;
		req.mode = mode;
		req.reg_ptr = {2'b00, ptr};
		req.wr_data = data;
		next_cycle();
		req.start = 1'b0;
	endtask

	task automatic wait_for_done(input string what);
		int cycles;
		cycles = 0;
		while (!status.done) begin
			if (cycles == DONE_LIMIT) begin
				timed_out(what);
			end
			next_cycle();
			cycles++;
		end
		next_cycle(); // done is sampled at the following edge
	endtask

	a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
		phase == PH_IDLE |-> scl && sda && !status.busy && !status.nack
			&& sample == '0 && rd_byte == '0)
		else check_failed("outputs after reset are not idle");

	a_write_done: assert property (@(posedge clk) disable iff (!rst_n)
		status.done && phase == PH_WRITE |-> !status.nack && u_sensor.regs[cpu_ptr] == cpu_data)
		else check_failed("cpu write did not reach the sensor register");

	a_read_done: assert property (@(posedge clk) disable iff (!rst_n)
		status.done && phase == PH_READ |-> !status.nack && rd_byte == u_sensor.regs[cpu_ptr])
		else check_failed("cpu read byte differs from the sensor register");

	a_burst_ack: assert property (@(posedge clk) disable iff (!rst_n)
		status.done && phase == PH_BURST |-> !status.nack)
		else check_failed("burst read ended with nack");

	// refused address leaves register, sample and read byte alone
	a_nack_done: assert property (@(posedge clk) disable iff (!rst_n)
		status.done && phase == PH_NACK |-> status.nack && u_sensor.regs[nack_ptr] == kept_reg
			&& rd_byte == cpu_data)
		else check_failed("refused write did not end as a clean nack");

	for (genvar f = 0; f < 7; f++) begin : g_field
		localparam int LO = BASE + 2 * f;
		logic [15:0] exp_field;
		assign exp_field = {u_sensor.regs[LO + 1], u_sensor.regs[LO]}; // high byte at odd reg
		a_sample_field: assert property (@(posedge clk) disable iff (!rst_n)
			status.done && (phase inside {PH_BURST, PH_NACK}) |-> sample[16*f +: 16] == exp_field)
			else check_failed($sformatf("sample field %0d differs from its register pair", f));
	end

	// only the master moves sda under a high scl, as start or stop
	a_sda_under_scl: assert property (@(posedge clk) disable iff (!rst_n)
		scl && $past(scl) && $changed(sda) |-> $changed(dut_sda_low) && !model_sda_low)
		else check_failed("sda changed while scl was high outside a start or stop");

	a_released_at_done: assert property (@(posedge clk) disable iff (!rst_n)
		status.done |-> scl && sda)
		else check_failed("bus lines not released at the end of a transaction");

	initial begin
		void'($urandom(32'h8d97));
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		drdy = 1'b0;
		nack_addr = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		phase = PH_RESET;
		cpu_ptr = 6'($urandom % 32);
		cpu_data = 8'($urandom);
		nack_ptr = '0;
		kept_reg = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		phase = PH_IDLE;
		repeat (4) next_cycle();

		for (int a = 0; a < `IMU_I2C_BURST_BYTES; a++) begin
			next_cycle();
			load_en = 1'b1;
			load_addr = 6'(BASE + a);
			load_data = 8'($urandom);
		end
		next_cycle();
		load_en = 1'b0;

		phase = PH_WRITE;
		send_cpu_req(imu_i2c_pkg::CPU_REG_WRITE, cpu_ptr, cpu_data);
		wait_for_done("cpu register write");

		phase = PH_READ;
		send_cpu_req(imu_i2c_pkg::CPU_REG_READ, cpu_ptr, 8'h00);
		wait_for_done("cpu register read");

		phase = PH_BURST;
		next_cycle();
		drdy = 1'b1;
		next_cycle();
		drdy = 1'b0;
		wait_for_done("data-ready burst");

		nack_ptr = 6'($urandom % 32);
		kept_reg = u_sensor.regs[nack_ptr];
		nack_addr = 1'b1;
		phase = PH_NACK;
		send_cpu_req(imu_i2c_pkg::CPU_REG_WRITE, nack_ptr, ~kept_reg);
		wait_for_done("refused cpu write");
		nack_addr = 1'b0;

		phase = PH_END;
		repeat (4) next_cycle();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* sim/imu_sensor_model.sv */
// Behavioral IMU sensor slave
`include "imu_i2c_defs.svh"

module imu_sensor_model (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_scl,
	input  logic       i_sda,
	input  logic       i_nack_addr,
	input  logic       i_load_en,
	input  logic [5:0] i_load_addr,
	input  logic [7:0] i_load_data,
	output logic       o_sda_low
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {
		M_IDLE,
		M_RX,
		M_TX
	} mode_t;

	logic [7:0] regs [64];
	mode_t mode;
	logic scl_q;
	logic sda_q;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [5:0] ptr;
	logic first_byte;
	logic ptr_next;
	logic read_dir;
	logic master_ack;
	logic start_seen;
	logic stop_seen;
	logic scl_rise;
	logic scl_fall;

	assign start_seen = scl_q && i_scl && sda_q && !i_sda;
	assign stop_seen = scl_q && i_scl && !sda_q && i_sda;
	assign scl_rise = !scl_q && i_scl;
	assign scl_fall = scl_q && !i_scl;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int a = 0; a < 64; a++) begin
				regs[a] <= 8'(a * 7 + 3);
			end
			mode <= M_IDLE;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			bit_cnt <= '0;
			shreg <= '0;
			ptr <= '0;
			first_byte <= 1'b0;
			ptr_next <= 1'b0;
			read_dir <= 1'b0;
			master_ack <= 1'b0;
			o_sda_low <= 1'b0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_load_en) begin
				regs[i_load_addr] <= i_load_data;
			end
			if (start_seen) begin
				mode <= M_RX;
				bit_cnt <= '0;
				first_byte <= 1'b1;
				o_sda_low <= 1'b0;
			end else if (stop_seen) begin
				mode <= M_IDLE;
				o_sda_low <= 1'b0;
			end else if (mode == M_RX) begin
				if (scl_rise && bit_cnt < 4'd8) begin
					shreg <= {shreg[6:0], i_sda};
					bit_cnt <= bit_cnt + 1'b1;
				end else if (scl_fall && bit_cnt == 4'd8) begin
					bit_cnt <= 4'd9;
					if (first_byte) begin
						first_byte <= 1'b0;
						if (shreg[7:1] == `IMU_I2C_DEV_ADDR && !i_nack_addr) begin
							o_sda_low <= 1'b1; // address ack
							read_dir <= shreg[0];
							ptr_next <= !shreg[0];
						end else begin
							mode <= M_IDLE; // not ours, stay off the bus
						end
					end else begin
						o_sda_low <= 1'b1;
						if (ptr_next) begin
							ptr <= shreg[5:0];
							ptr_next <= 1'b0;
						end else begin
							regs[ptr] <= shreg;
							ptr <= ptr + 1'b1;
						end
					end
				end else if (scl_fall && bit_cnt == 4'd9) begin
					bit_cnt <= '0;
					if (read_dir) begin
						mode <= M_TX;
						shreg <= regs[ptr];
						ptr <= ptr + 1'b1;
						o_sda_low <= !regs[ptr][7];
					end else begin
						o_sda_low <= 1'b0;
					end
				end
			end else if (mode == M_TX) begin
				if (scl_rise) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 4'd8) begin
						master_ack <= !i_sda;
					end
				end else if (scl_fall) begin
					if (bit_cnt < 4'd8) begin
						shreg <= {shreg[6:0], 1'b0};
						o_sda_low <= !shreg[6];
					end else if (bit_cnt == 4'd8) begin
						o_sda_low <= 1'b0; // master ack slot
					end else if (master_ack) begin
						bit_cnt <= '0;
						shreg <= regs[ptr];
						ptr <= ptr + 1'b1;
						o_sda_low <= !regs[ptr][7];
					end else begin
						mode <= M_IDLE;
						o_sda_low <= 1'b0;
					end
				end
			end
		end
	end

endmodule

/* hw/imu_i2c_top.sv */
// IMU I2C master top level
module imu_i2c_top (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  imu_i2c_pkg::cpu_req_t     i_req,
	input  logic                      i_drdy,
	input  logic                      i_sda,
	output logic                      o_scl_low,
	output logic                      o_sda_low,
	output imu_i2c_pkg::imu_sample_t  o_sample,
	output logic [7:0]                o_rd_byte,
	output imu_i2c_pkg::imu_status_t  o_status
);

	logic qtr_tick;
	logic link_active;
	logic link_done;
	logic cmd_valid;
	imu_i2c_pkg::link_cmd_t link_cmd;
	imu_i2c_pkg::link_rsp_t link_rsp;

	i2c_bit_timer u_bit_timer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_enable   (link_active),
		.o_qtr_tick (qtr_tick)
	);

	i2c_byte_engine u_byte_engine (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_qtr_tick  (qtr_tick),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (link_cmd),
		.o_done      (link_done),
		.o_rsp       (link_rsp),
		.o_active    (link_active),
		.o_scl_low   (o_scl_low),
		.o_sda_low   (o_sda_low),
		.i_sda       (i_sda)
	);

	imu_sequencer u_sequencer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_req       (i_req),
		.i_drdy      (i_drdy),
		.i_link_done (link_done),
		.i_link_rsp  (link_rsp),
		.o_cmd_valid (cmd_valid),
		.o_cmd       (link_cmd),
		.o_sample    (o_sample),
		.o_rd_byte   (o_rd_byte),
		.o_status    (o_status)
	);

endmodule

/* hw/imu_sequencer.sv */
// IMU transaction sequencer
`include "imu_i2c_defs.svh"

module imu_sequencer (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  imu_i2c_pkg::cpu_req_t     i_req,
	input  logic                      i_drdy,
	input  logic                      i_link_done,
	input  imu_i2c_pkg::link_rsp_t    i_link_rsp,
	output logic                      o_cmd_valid,
	output imu_i2c_pkg::link_cmd_t    o_cmd,
	output imu_i2c_pkg::imu_sample_t  o_sample,
	output logic [7:0]                o_rd_byte,
	output imu_i2c_pkg::imu_status_t  o_status
);

	localparam int CNT_W = $clog2(`IMU_I2C_BURST_BYTES);

	typedef enum logic [3:0] {
		S_START1,
		S_ADDR_W,
		S_PTR,
		S_DATA,
		S_STOP1,
		S_START2,
		S_ADDR_R,
		S_READ,
		S_STOP_END
	} step_t;

	step_t st;
	step_t nxt_st;
	logic [CNT_W-1:0] rd_cnt;
	logic [CNT_W-1:0] nxt_cnt;
	logic [CNT_W-1:0] last_idx;
	logic busy_r;
	logic done_r;
	logic nack_r;
	logic cmd_valid_r;
	logic is_burst;
	logic ack_miss;
	logic job_start;
	logic step_adv;
	logic job_end;
	imu_i2c_pkg::cpu_mode_t mode_r;
	imu_i2c_pkg::link_cmd_t cmd_r;
	imu_i2c_pkg::link_cmd_t nxt_cmd;
	imu_i2c_pkg::imu_burst_u burst_r;
	logic [7:0] ptr_r;
	logic [7:0] wdata_r;

	assign job_start = !busy_r && (i_req.start || i_drdy);
	assign step_adv = busy_r && i_link_done && (st != S_STOP_END);
	assign job_end = busy_r && i_link_done && (st == S_STOP_END);
	assign last_idx = is_burst ? CNT_W'(`IMU_I2C_BURST_BYTES - 1) : '0;

	always_comb begin
		nxt_st = st;
		nxt_cnt = rd_cnt;
		ack_miss = 1'b0;
		case (st)
			S_START1: nxt_st = S_ADDR_W;
			S_ADDR_W: nxt_st = S_PTR;
			S_PTR: begin
				if (!is_burst && mode_r == imu_i2c_pkg::CPU_REG_WRITE) begin
					nxt_st = S_DATA;
				end else begin
					nxt_st = S_STOP1; // pointer set, restart for reading
				end
			end
			S_DATA:   nxt_st = S_STOP_END;
			S_STOP1:  nxt_st = S_START2;
			S_START2: nxt_st = S_ADDR_R;
			S_ADDR_R: begin
				nxt_st = S_READ;
				nxt_cnt = '0;
			end
			S_READ: begin
				if (rd_cnt == last_idx) begin
					nxt_st = S_STOP_END;
				end else begin
					nxt_cnt = rd_cnt + 1'b1;
				end
			end
			default: nxt_st = S_STOP_END;
		endcase
		if ((st inside {S_ADDR_W, S_PTR, S_DATA, S_ADDR_R}) && !i_link_rsp.ack_seen) begin
			ack_miss = 1'b1;
			nxt_st = S_STOP_END; // abort with stop
		end
	end

	always_comb begin
		nxt_cmd.op = imu_i2c_pkg::LINK_WRITE;
		nxt_cmd.data = '0;
		nxt_cmd.send_ack = 1'b0;
		case (nxt_st)
			S_START1, S_START2: nxt_cmd.op = imu_i2c_pkg::LINK_START;
			S_STOP1, S_STOP_END: nxt_cmd.op = imu_i2c_pkg::LINK_STOP;
			S_ADDR_W: nxt_cmd.data = {`IMU_I2C_DEV_ADDR, 1'b0};
			S_ADDR_R: nxt_cmd.data = {`IMU_I2C_DEV_ADDR, 1'b1};
			S_PTR:    nxt_cmd.data = ptr_r;
			S_DATA:   nxt_cmd.data = wdata_r;
			default: begin
				nxt_cmd.op = imu_i2c_pkg::LINK_READ;
				nxt_cmd.send_ack = (nxt_cnt != last_idx); // nack the final byte
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_r <= 1'b0;
			done_r <= 1'b0;
			nack_r <= 1'b0;
			cmd_valid_r <= 1'b0;
			st <= S_START1;
			rd_cnt <= '0;
			is_burst <= 1'b0;
			mode_r <= imu_i2c_pkg::CPU_REG_READ;
			o_sample <= '0;
			o_rd_byte <= '0;
		end else begin
			cmd_valid_r <= job_start || step_adv;
			done_r <= job_end;
			if (job_start) begin
				busy_r <= 1'b1;
				nack_r <= 1'b0;
				st <= S_START1;
				is_burst <= !i_req.start; // cpu request has priority
				mode_r <= i_req.mode;
			end else if (step_adv) begin
				st <= nxt_st;
				rd_cnt <= nxt_cnt;
				if (ack_miss) begin
					nack_r <= 1'b1;
				end
			end else if (job_end) begin
				busy_r <= 1'b0;
				if (!nack_r && is_burst) begin
					o_sample <= burst_r.sample;
				end else if (!nack_r && mode_r == imu_i2c_pkg::CPU_REG_READ) begin
					o_rd_byte <= burst_r.bytes[0];
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (job_start) begin
			cmd_r <= '{imu_i2c_pkg::LINK_START, 8'h00, 1'b0};
			ptr_r <= i_req.start ? i_req.reg_ptr : `IMU_I2C_REG_BURST_BASE;
			wdata_r <= i_req.wr_data;
		end else if (step_adv) begin
			cmd_r <= nxt_cmd;
		end
		if (busy_r && i_link_done && st == S_READ) begin
			burst_r.bytes[rd_cnt] <= i_link_rsp.data;
		end
	end

	assign o_cmd_valid = cmd_valid_r;
	assign o_cmd = cmd_r;
	assign o_status.busy = busy_r;
	assign o_status.done = done_r;
	assign o_status.nack = nack_r;

	a_done_is_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		done_r |-> !cmd_valid_r && !busy_r);

endmodule

/* i2c_link/i2c_byte_engine.sv */
// I2C byte engine
`include "imu_i2c_defs.svh"

module i2c_byte_engine (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_qtr_tick,
	input  logic                    i_cmd_valid,
	input  imu_i2c_pkg::link_cmd_t  i_cmd,
	output logic                    o_done,
	output imu_i2c_pkg::link_rsp_t  o_rsp,
	output logic                    o_active,
	output logic                    o_scl_low,
	output logic                    o_sda_low,
	input  logic                    i_sda
);

	localparam int BW = `IMU_I2C_BYTE_W;
	localparam int BYTE_STEPS = 4 * (BW + 1); // data bits plus ack bit
	localparam int STEP_W = $clog2(BYTE_STEPS);

	imu_i2c_pkg::link_op_t op_r;
	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] nstep;
	logic [STEP_W-3:0] nbit;
	logic [BW-1:0] shreg;
	logic send_ack_r;
	logic ack_r;
	logic active;
	logic scl_low;
	logic sda_low;
	logic is_byte;
	logic last_step;
	logic next_bit_low;

	assign nstep = step + 1'b1;
	assign nbit = nstep[STEP_W-1:2];
	assign is_byte = (op_r == imu_i2c_pkg::LINK_WRITE) || (op_r == imu_i2c_pkg::LINK_READ);
	assign last_step = is_byte ? (step == STEP_W'(BYTE_STEPS - 1)) : (step == STEP_W'(3));
	assign o_done = active && i_qtr_tick && last_step;

	// sda level for the low phase of the next bit
	always_comb begin
		if (nbit < (STEP_W-2)'(BW)) begin
			next_bit_low = (op_r == imu_i2c_pkg::LINK_WRITE) && !shreg[BW-1];
		end else begin
			next_bit_low = (op_r == imu_i2c_pkg::LINK_READ) && send_ack_r; // master ack slot
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active <= 1'b0;
			step <= '0;
			op_r <= imu_i2c_pkg::LINK_STOP;
			scl_low <= 1'b0;
			sda_low <= 1'b0;
		end else if (i_cmd_valid) begin
			active <= 1'b1;
			step <= '0;
			op_r <= i_cmd.op;
			case (i_cmd.op)
				imu_i2c_pkg::LINK_STOP:  sda_low <= 1'b1; // scl is low here
				imu_i2c_pkg::LINK_WRITE: sda_low <= !i_cmd.data[BW-1];
				default:                 sda_low <= 1'b0; // start releases first
			endcase
		end else if (active && i_qtr_tick) begin
			if (last_step) begin
				active <= 1'b0;
			end else begin
				step <= nstep;
				case (nstep[1:0])
					2'd0: sda_low <= next_bit_low;
					2'd1: scl_low <= 1'b0;
					2'd2: begin
						if (op_r == imu_i2c_pkg::LINK_START) begin
							sda_low <= 1'b1; // start condition
						end else if (op_r == imu_i2c_pkg::LINK_STOP) begin
							sda_low <= 1'b0; // stop condition
						end
					end
					default: begin
						if (op_r != imu_i2c_pkg::LINK_STOP) begin
							scl_low <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// shift at mid-high, ack slot last
	always_ff @(posedge i_clk) begin
		if (i_cmd_valid) begin
			shreg <= i_cmd.data;
			send_ack_r <= i_cmd.send_ack;
		end else if (active && i_qtr_tick && !last_step && is_byte && nstep[1:0] == 2'd2) begin
			if (nbit < (STEP_W-2)'(BW)) begin
				shreg <= {shreg[BW-2:0], i_sda};
			end else begin
				ack_r <= !i_sda;
			end
		end
	end

	assign o_rsp.data = shreg;
	assign o_rsp.ack_seen = ack_r;
	assign o_active = active;
	assign o_scl_low = scl_low;
	assign o_sda_low = sda_low;

	// sequencer waits for done before the next command
	a_cmd_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cmd_valid |-> !active || o_done);

	// sda only moves under a released scl for start or stop
	a_sda_stable_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!scl_low && $stable(scl_low) && $changed(sda_low))
			|-> (op_r inside {imu_i2c_pkg::LINK_START, imu_i2c_pkg::LINK_STOP}));

endmodule

/* i2c_link/i2c_bit_timer.sv */
// I2C quarter-bit tick generator
`include "imu_i2c_defs.svh"

module i2c_bit_timer #(
	parameter int unsigned QTR_CYCLES = `IMU_I2C_QTR_CYCLES
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_enable,
	output logic o_qtr_tick
);

	localparam int CNT_W = $clog2(QTR_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(QTR_CYCLES - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (!i_enable) begin
			cnt <= '0; // parked so the first tick is a full quarter away
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_qtr_tick = i_enable && (cnt == CNT_LAST);

endmodule

/* common/imu_i2c_pkg.sv */
// IMU I2C shared types
`include "imu_i2c_defs.svh"

package imu_i2c_pkg;

	typedef enum logic [1:0] {
		LINK_START,
		LINK_STOP,
		LINK_WRITE,
		LINK_READ
	} link_op_t;

	typedef struct packed {
		link_op_t op;
		logic [`IMU_I2C_BYTE_W-1:0] data;
		logic send_ack; // read only, clear sends NACK
	} link_cmd_t;

	typedef struct packed {
		logic [`IMU_I2C_BYTE_W-1:0] data;
		logic ack_seen;
	} link_rsp_t;

	typedef enum logic {
		CPU_REG_READ,
		CPU_REG_WRITE
	} cpu_mode_t;

	typedef struct packed {
		logic start;
		cpu_mode_t mode;
		logic [7:0] reg_ptr;
		logic [7:0] wr_data;
	} cpu_req_t;

	// declared high to low so temp lands on bytes 0/1
	typedef struct packed {
		logic signed [15:0] accel_z;
		logic signed [15:0] accel_y;
		logic signed [15:0] accel_x;
		logic signed [15:0] gyro_z;
		logic signed [15:0] gyro_y;
		logic signed [15:0] gyro_x;
		logic signed [15:0] temp;
	} imu_sample_t;

	typedef union packed {
		logic [`IMU_I2C_BURST_BYTES-1:0][`IMU_I2C_BYTE_W-1:0] bytes; // byte 0 is reg 0x20
		imu_sample_t sample;
	} imu_burst_u;

	typedef struct packed {
		logic busy;
		logic done;
		logic nack;
	} imu_status_t;

endpackage

/* common/imu_i2c_defs.svh */
// IMU I2C link constants
`ifndef IMU_I2C_DEFS_SVH
`define IMU_I2C_DEFS_SVH

// 7-bit sensor address, SA0 tied low
`define IMU_I2C_DEV_ADDR 7'h6A

// OUT_TEMP_L, first register of the burst
`define IMU_I2C_REG_BURST_BASE 8'h20

// temp, gyro xyz, accel xyz as low/high pairs
`define IMU_I2C_BURST_BYTES 14

// i_clk cycles per quarter SCL period
`define IMU_I2C_QTR_CYCLES 4

`define IMU_I2C_BYTE_W 8

`endif
